// File: hdl/pitaya_pkg.sv
//////////////////////////////////////////////////////////////////////
// analog path shared definitions
// widths, bus regions, housekeeping map and sample arithmetic
//////////////////////////////////////////////////////////////////////

package pitaya_pkg;

  localparam int ADC_PIN_W = 16;  // raw ADC pins, two low bits reserved
  localparam int SAMPLE_W  = 14;

  typedef logic signed [SAMPLE_W-1:0] sample_t;    // two's complement
  typedef logic        [SAMPLE_W-1:0] dac_code_t;  // negative slope offset binary
  typedef logic signed [SAMPLE_W:0]   sum_t;       // one guard bit above sample
  typedef logic        [31:0]         bus_addr_t;
  typedef logic        [31:0]         bus_data_t;

  // region field of the system bus address
  localparam int REGION_LSB  = 20;
  localparam int REGION_W    = 3;
  localparam int NUM_REGIONS = 8;

  typedef logic [REGION_W-1:0]   region_t;
  typedef logic [REGION_LSB-1:0] hk_off_t;  // byte offset inside a region

  localparam region_t REGION_HK      = 3'd0;
  localparam region_t REGION_SAMPLES = 3'd1;

  // housekeeping register map
  localparam hk_off_t HK_ID       = 20'h00;
  localparam hk_off_t HK_LED      = 20'h04;
  localparam hk_off_t HK_LEVEL_A  = 20'h10;
  localparam hk_off_t HK_LEVEL_B  = 20'h14;
  localparam hk_off_t HK_OFFSET_A = 20'h18;
  localparam hk_off_t HK_OFFSET_B = 20'h1C;
  localparam hk_off_t HK_SAT      = 20'h20;

  localparam bus_data_t HK_ID_VALUE = 32'h5A17_0E14;

  // clamp a sum back into sample range, clip flags the clamp
  function automatic sample_t saturate(input sum_t s, output logic clip);
    sample_t r;
    clip = s[SAMPLE_W] ^ s[SAMPLE_W-1];  // guard bit disagrees with sign
    if (clip)
      r = {s[SAMPLE_W], {(SAMPLE_W-1){~s[SAMPLE_W]}}};  // full scale, sign kept
    else
      r = s[SAMPLE_W-1:0];
    return r;
  endfunction

  // sign bit stays, magnitude bits flip; works both ways
  function automatic dac_code_t to_dac_code(input sample_t s);
    return {s[SAMPLE_W-1], ~s[SAMPLE_W-2:0]};
  endfunction

endpackage

// File: hdl/sys_bus_decoder.sv
//////////////////////////////////////////////////////////////////////
// system bus decoder
// splits the address space into 8 regions, answers the unused ones
//////////////////////////////////////////////////////////////////////

module sys_bus_decoder (
  input  logic                  adc_clk,
  input  logic                  reset_i,
  input  pitaya_pkg::bus_addr_t sys_addr_i,
  input  logic                  sys_wen_i,
  input  logic                  sys_ren_i,
  input  pitaya_pkg::bus_data_t hk_rdata_i,
  input  logic                  hk_ack_i,
  input  logic                  hk_err_i,
  input  pitaya_pkg::bus_data_t smp_rdata_i,
  input  logic                  smp_ack_i,
  input  logic                  smp_err_i,
  output logic                  hk_wen_o,
  output logic                  hk_ren_o,
  output logic                  smp_wen_o,
  output logic                  smp_ren_o,
  output pitaya_pkg::bus_data_t sys_rdata_o,
  output logic                  sys_ack_o,
  output logic                  sys_err_o
);

  pitaya_pkg::region_t                region;
  pitaya_pkg::region_t                region_q;    // region of the access in flight
  logic [pitaya_pkg::NUM_REGIONS-1:0] cs;          // one-hot chip select
  logic                               strobe;
  logic                               dflt_ack_q;  // own answer for unused regions

  assign region = sys_addr_i[pitaya_pkg::REGION_LSB +: pitaya_pkg::REGION_W];
  assign strobe = sys_wen_i | sys_ren_i;

  always_comb
  begin
    cs         = '0;
    cs[region] = 1'b1;
  end

  // strobe routing
  assign hk_wen_o  = sys_wen_i & cs[pitaya_pkg::REGION_HK];
  assign hk_ren_o  = sys_ren_i & cs[pitaya_pkg::REGION_HK];
  assign smp_wen_o = sys_wen_i & cs[pitaya_pkg::REGION_SAMPLES];
  assign smp_ren_o = sys_ren_i & cs[pitaya_pkg::REGION_SAMPLES];

  always_ff @(posedge adc_clk)
  begin
    if (reset_i)
    begin
      region_q   <= '0;
      dflt_ack_q <= 1'b0;
    end
    else
    begin
      if (strobe)
        region_q <= region;  // held until the next access
      dflt_ack_q <= strobe & ~(cs[pitaya_pkg::REGION_HK] | cs[pitaya_pkg::REGION_SAMPLES]);
    end
  end

  ////////////////////////////////////////////////////////////////////
  // return path
  ////////////////////////////////////////////////////////////////////

  always_comb
  begin
    sys_rdata_o = '0;          // unused regions read zero
    sys_ack_o   = dflt_ack_q;
    sys_err_o   = 1'b0;
    if (region_q == pitaya_pkg::REGION_HK)
    begin
      sys_rdata_o = hk_rdata_i;
      sys_ack_o   = hk_ack_i;
      sys_err_o   = hk_err_i;
    end
    else if (region_q == pitaya_pkg::REGION_SAMPLES)
    begin
      sys_rdata_o = smp_rdata_i;
      sys_ack_o   = smp_ack_i;
      sys_err_o   = smp_err_i;
    end
  end

  // slaves and own answer never collide
  a_single_ack: assert property (@(posedge adc_clk) disable iff (reset_i)
    $onehot0({hk_ack_i, smp_ack_i, dflt_ack_q}));

endmodule

// File: hdl/housekeeping_regs.sv
//////////////////////////////////////////////////////////////////////
// housekeeping register block, region 0
// LEDs, mixer levels and offsets, sticky saturation flags
//////////////////////////////////////////////////////////////////////

module housekeeping_regs #(
  parameter int NUM_LEDS = 8  // up to 32
) (
  input  logic                  adc_clk,
  input  logic                  reset_i,
  input  pitaya_pkg::bus_addr_t addr_i,
  input  pitaya_pkg::bus_data_t wdata_i,
  input  logic                  wen_i,
  input  logic                  ren_i,
  input  logic                  sat_a_i,     // clip pulse, channel A
  input  logic                  sat_b_i,
  output pitaya_pkg::bus_data_t rdata_o,
  output logic                  ack_o,
  output logic                  err_o,
  output logic [NUM_LEDS-1:0]   led_o,
  output pitaya_pkg::sample_t   level_a_o,
  output pitaya_pkg::sample_t   level_b_o,
  output pitaya_pkg::sample_t   offset_a_o,
  output pitaya_pkg::sample_t   offset_b_o
);

  localparam int SW = pitaya_pkg::SAMPLE_W;

  pitaya_pkg::hk_off_t   off;
  pitaya_pkg::bus_data_t rd_mux;
  logic                  known;    // offset hits a register
  logic                  sat_clr;  // any write to HK_SAT
  logic [1:0]            sat_q;    // bit 0 channel A, bit 1 channel B

  assign off     = addr_i[pitaya_pkg::REGION_LSB-1:0];
  assign sat_clr = wen_i && (off == pitaya_pkg::HK_SAT);

  // read mux, narrow fields zero extended
  always_comb
  begin
    rd_mux = '0;
    known  = 1'b1;
    case (off)
      pitaya_pkg::HK_ID:       rd_mux                = pitaya_pkg::HK_ID_VALUE;
      pitaya_pkg::HK_LED:      rd_mux[NUM_LEDS-1:0]  = led_o;
      pitaya_pkg::HK_LEVEL_A:  rd_mux[SW-1:0]        = level_a_o;
      pitaya_pkg::HK_LEVEL_B:  rd_mux[SW-1:0]        = level_b_o;
      pitaya_pkg::HK_OFFSET_A: rd_mux[SW-1:0]        = offset_a_o;
      pitaya_pkg::HK_OFFSET_B: rd_mux[SW-1:0]        = offset_b_o;
      pitaya_pkg::HK_SAT:      rd_mux[1:0]           = sat_q;
      default:                 known                 = 1'b0;
    endcase
  end

  always_ff @(posedge adc_clk)
  begin
    if (reset_i)
    begin
      led_o      <= '0;
      level_a_o  <= '0;
      level_b_o  <= '0;
      offset_a_o <= '0;
      offset_b_o <= '0;
      sat_q      <= '0;
      ack_o      <= 1'b0;
      err_o      <= 1'b0;
    end
    else
    begin
      if (wen_i)
      begin
        case (off)
          pitaya_pkg::HK_LED:      led_o      <= wdata_i[NUM_LEDS-1:0];
          pitaya_pkg::HK_LEVEL_A:  level_a_o  <= wdata_i[SW-1:0];
          pitaya_pkg::HK_LEVEL_B:  level_b_o  <= wdata_i[SW-1:0];
          pitaya_pkg::HK_OFFSET_A: offset_a_o <= wdata_i[SW-1:0];
          pitaya_pkg::HK_OFFSET_B: offset_b_o <= wdata_i[SW-1:0];
          default: ;  // ID and SAT handled elsewhere
        endcase
      end
      // a clip in the clear cycle wins
      sat_q[0] <= sat_a_i | (sat_q[0] & ~sat_clr);
      sat_q[1] <= sat_b_i | (sat_q[1] & ~sat_clr);
      ack_o    <= wen_i | ren_i;  // always one cycle
      err_o    <= (wen_i | ren_i) & (~known | (wen_i & (off == pitaya_pkg::HK_ID)));
    end
  end

  // read data only, valid with ack
  always_ff @(posedge adc_clk)
  begin
    if (ren_i)
      rdata_o <= rd_mux;
  end

  // read and write strobes never overlap
  a_one_strobe: assert property (@(posedge adc_clk) disable iff (reset_i)
    !(wen_i && ren_i));

endmodule

// File: hdl/adc_front_end.sv
//////////////////////////////////////////////////////////////////////
// ADC front end and region 1 sample window
// captures both channels and turns the ADC code into samples
//////////////////////////////////////////////////////////////////////

module adc_front_end (
  input  logic                               adc_clk,
  input  logic                               reset_i,
  input  logic [pitaya_pkg::ADC_PIN_W-1:0]   adc_dat_a_i,
  input  logic [pitaya_pkg::ADC_PIN_W-1:0]   adc_dat_b_i,
  input  logic                               wen_i,
  input  logic                               ren_i,
  output pitaya_pkg::sample_t                a_sample_o,
  output pitaya_pkg::sample_t                b_sample_o,
  output pitaya_pkg::bus_data_t              rdata_o,
  output logic                               ack_o,
  output logic                               err_o
);

  localparam int SW = pitaya_pkg::SAMPLE_W;

  pitaya_pkg::dac_code_t a_raw;  // top 14 pins, low 2 reserved
  pitaya_pkg::dac_code_t b_raw;

  assign a_raw = adc_dat_a_i[pitaya_pkg::ADC_PIN_W-1 -: SW];
  assign b_raw = adc_dat_b_i[pitaya_pkg::ADC_PIN_W-1 -: SW];

  ////////////////////////////////////////////////////////////////////
  // capture, converted on the way in
  ////////////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk)
  begin
    if (reset_i)
    begin
      a_sample_o <= '0;
      b_sample_o <= '0;
    end
    else
    begin
      a_sample_o <= pitaya_pkg::to_dac_code(a_raw);  // same flip as the DAC side
      b_sample_o <= pitaya_pkg::to_dac_code(b_raw);
    end
  end

  // read-only window onto the current samples
  always_ff @(posedge adc_clk)
  begin
    if (reset_i)
    begin
      ack_o <= 1'b0;
      err_o <= 1'b0;
    end
    else
    begin
      ack_o <= wen_i | ren_i;
      err_o <= wen_i;  // writes are refused
    end
  end

  always_ff @(posedge adc_clk)
  begin
    if (ren_i)
      rdata_o <= {{(16-SW){b_sample_o[SW-1]}}, b_sample_o,   // B in the upper half
                  {(16-SW){a_sample_o[SW-1]}}, a_sample_o};
  end

endmodule

// File: hdl/dac_mixer.sv
//////////////////////////////////////////////////////////////////////
// DAC channel mixer
// two saturating sum stages, then the registered DAC code
//////////////////////////////////////////////////////////////////////

module dac_mixer (
  input  logic                  adc_clk,
  input  logic                  reset_i,
  input  pitaya_pkg::sample_t   sample_i,    // from the ADC capture
  input  pitaya_pkg::sample_t   level_i,     // stage one addend
  input  pitaya_pkg::sample_t   offset_i,    // stage two addend
  output pitaya_pkg::dac_code_t dac_code_o,
  output logic                  sat_o        // one cycle per clipped sample
);

  pitaya_pkg::sum_t    sum1;
  pitaya_pkg::sum_t    sum2;
  pitaya_pkg::sample_t st1_d;
  pitaya_pkg::sample_t st2_d;
  logic                clip1_d;
  logic                clip2_d;
  pitaya_pkg::sample_t st1_q;    // stage one result
  pitaya_pkg::sample_t st2_q;    // stage two result
  logic                clip1_q;  // stage one clip, travels with st1_q

  always_comb
  begin
    sum1  = pitaya_pkg::sum_t'(sample_i) + pitaya_pkg::sum_t'(level_i);
    st1_d = pitaya_pkg::saturate(sum1, clip1_d);
    sum2  = pitaya_pkg::sum_t'(st1_q) + pitaya_pkg::sum_t'(offset_i);
    st2_d = pitaya_pkg::saturate(sum2, clip2_d);
  end

  ////////////////////////////////////////////////////////////////////
  // pipeline, three samples in flight
  ////////////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk)
  begin
    if (reset_i)
    begin
      st1_q      <= '0;
      clip1_q    <= 1'b0;
      st2_q      <= '0;
      sat_o      <= 1'b0;
      dac_code_o <= pitaya_pkg::to_dac_code('0);  // mid scale, 0x1FFF
    end
    else
    begin
      st1_q      <= st1_d;
      clip1_q    <= clip1_d;
      st2_q      <= st2_d;
      sat_o      <= clip1_q | clip2_d;  // either stage
      dac_code_o <= pitaya_pkg::to_dac_code(st2_q);
    end
  end

  // flag feeds a sticky register, must stay clean
  a_sat_known: assert property (@(posedge adc_clk) disable iff (reset_i)
    !$isunknown(sat_o));

endmodule

// File: hdl/pitaya_analog_top.sv
//////////////////////////////////////////////////////////////////////
// analog data path top with register bus
//////////////////////////////////////////////////////////////////////

module pitaya_analog_top #(
  parameter int NUM_LEDS = 8
) (
  input  logic                             adc_clk,
  input  logic                             reset_i,
  input  logic [pitaya_pkg::ADC_PIN_W-1:0] adc_dat_a_i,
  input  logic [pitaya_pkg::ADC_PIN_W-1:0] adc_dat_b_i,
  input  pitaya_pkg::bus_addr_t            sys_addr_i,
  input  pitaya_pkg::bus_data_t            sys_wdata_i,
  input  logic                             sys_wen_i,
  input  logic                             sys_ren_i,
  output pitaya_pkg::bus_data_t            sys_rdata_o,
  output logic                             sys_ack_o,
  output logic                             sys_err_o,
  output pitaya_pkg::dac_code_t            dac_dat_a_o,
  output pitaya_pkg::dac_code_t            dac_dat_b_o,
  output logic [NUM_LEDS-1:0]              led_o
);

  // region strobes and returns
  logic                  hk_wen, hk_ren, hk_ack, hk_err;
  logic                  smp_wen, smp_ren, smp_ack, smp_err;
  pitaya_pkg::bus_data_t hk_rdata, smp_rdata;

  // data path
  pitaya_pkg::sample_t   a_sample, b_sample;
  pitaya_pkg::sample_t   level_a, level_b, offset_a, offset_b;
  logic                  sat_a, sat_b;

  sys_bus_decoder decoder_i (
    .adc_clk     (adc_clk),
    .reset_i     (reset_i),
    .sys_addr_i  (sys_addr_i),
    .sys_wen_i   (sys_wen_i),
    .sys_ren_i   (sys_ren_i),
    .hk_rdata_i  (hk_rdata),
    .hk_ack_i    (hk_ack),
    .hk_err_i    (hk_err),
    .smp_rdata_i (smp_rdata),
    .smp_ack_i   (smp_ack),
    .smp_err_i   (smp_err),
    .hk_wen_o    (hk_wen),
    .hk_ren_o    (hk_ren),
    .smp_wen_o   (smp_wen),
    .smp_ren_o   (smp_ren),
    .sys_rdata_o (sys_rdata_o),
    .sys_ack_o   (sys_ack_o),
    .sys_err_o   (sys_err_o)
  );

  housekeeping_regs #(.NUM_LEDS(NUM_LEDS)) hk_i (
    .adc_clk    (adc_clk),
    .reset_i    (reset_i),
    .addr_i     (sys_addr_i),
    .wdata_i    (sys_wdata_i),
    .wen_i      (hk_wen),
    .ren_i      (hk_ren),
    .sat_a_i    (sat_a),
    .sat_b_i    (sat_b),
    .rdata_o    (hk_rdata),
    .ack_o      (hk_ack),
    .err_o      (hk_err),
    .led_o      (led_o),
    .level_a_o  (level_a),
    .level_b_o  (level_b),
    .offset_a_o (offset_a),
    .offset_b_o (offset_b)
  );

  adc_front_end adc_i (
    .adc_clk     (adc_clk),
    .reset_i     (reset_i),
    .adc_dat_a_i (adc_dat_a_i),
    .adc_dat_b_i (adc_dat_b_i),
    .wen_i       (smp_wen),
    .ren_i       (smp_ren),
    .a_sample_o  (a_sample),
    .b_sample_o  (b_sample),
    .rdata_o     (smp_rdata),
    .ack_o       (smp_ack),
    .err_o       (smp_err)
  );

  dac_mixer mixer_a (
    .adc_clk    (adc_clk),
    .reset_i    (reset_i),
    .sample_i   (a_sample),
    .level_i    (level_a),
    .offset_i   (offset_a),
    .dac_code_o (dac_dat_a_o),
    .sat_o      (sat_a)
  );

  dac_mixer mixer_b (
    .adc_clk    (adc_clk),
    .reset_i    (reset_i),
    .sample_i   (b_sample),
    .level_i    (level_b),
    .offset_i   (offset_b),
    .dac_code_o (dac_dat_b_o),
    .sat_o      (sat_b)
  );

endmodule

// File: include/tb_pitaya_cases.svh
//////////////////////////////////////////////////////////////////////
// mixer test table and reference model
// ADC code, saturation and DAC code arithmetic done on integers
//////////////////////////////////////////////////////////////////////

`ifndef TB_PITAYA_CASES_SVH
`define TB_PITAYA_CASES_SVH

typedef struct packed {
  logic        rnd;       // ADC pins drawn at run time
  logic [15:0] raw_a;
  logic [15:0] raw_b;
  int          level_a;
  int          level_b;
  int          offset_a;
  int          offset_b;
  logic [13:0] exp_a;     // expected DAC codes
  logic [13:0] exp_b;
  logic [1:0]  exp_sat;   // bit 0 channel A
} mix_case_t;

localparam int          NUM_CASES = 10;
localparam logic [31:0] RNG_SEED  = 32'hc134_3161;

// expected fields filled by prepare_cases
mix_case_t cases [NUM_CASES] = '{
  '{1'b0, 16'h7FFC, 16'h7FFF,   100,  -200,     0,     0, '0, '0, '0},  // mid scale
  '{1'b0, 16'h0000, 16'hFFFC,    10,   -10,     0,     0, '0, '0, '0},  // stage one clips
  '{1'b0, 16'h4000, 16'hC000,  4000, -4000,   200,  -100, '0, '0, '0},  // stage two clips
  '{1'b0, 16'h8000, 16'h2468,     0,     0,     0,     0, '0, '0, '0},  // flags clear again
  '{1'b0, 16'h0000, 16'h7FFC,  5000,     0, -3000,  1234, '0, '0, '0},
  '{1'b0, 16'h6000, 16'hFFFC,   -50,     0,    50,    -1, '0, '0, '0},  // B only
  '{1'b1, 16'h0000, 16'h0000,  3000, -3000,  2000, -2000, '0, '0, '0},
  '{1'b1, 16'h0000, 16'h0000,     0,     0,     0,     0, '0, '0, '0},
  '{1'b1, 16'h0000, 16'h0000, -7000,  7000,   500,  -500, '0, '0, '0},
  '{1'b1, 16'h0000, 16'h0000,  8191, -8192,     0,     0, '0, '0, '0}   // full scale
};

// code falls as the voltage rises, 8191 at code 0
function automatic int adc_to_sample(input logic [15:0] pins);
  return 8191 - int'(pins[15:2]);  // two low pins reserved
endfunction

function automatic int clamp_sample(input int v, output logic clip);
  int r;
  clip = 1'b1;
  if (v > 8191)
    r = 8191;
  else if (v < -8192)
    r = -8192;
  else
  begin
    r    = v;
    clip = 1'b0;
  end
  return r;
endfunction

function automatic logic [13:0] dac_code_of(input int s);
  int c;
  c = 8191 - s;  // same slope as the ADC
  return c[13:0];
endfunction

function automatic logic [31:0] xorshift32(input logic [31:0] x);
  logic [31:0] y;
  y = x ^ (x << 13);
  y = y ^ (y >> 17);
  y = y ^ (y << 5);
  return y;
endfunction

// region 1 word, each sample sign extended to 16 bits
function automatic logic [31:0] window_word(input logic [15:0] pa, input logic [15:0] pb);
  int sa;
  int sb;
  sa = adc_to_sample(pa);
  sb = adc_to_sample(pb);
  return {sb[15:0], sa[15:0]};
endfunction

task automatic prepare_cases();
  logic [31:0] state;
  int          s1;
  int          sa;
  int          sb;
  logic        c1;
  logic        c2;
  logic        c3;
  logic        c4;
  state = RNG_SEED;
  for (int i = 0; i < NUM_CASES; i++)
  begin
    if (cases[i].rnd)
    begin
      state         = xorshift32(state);
      cases[i].raw_a = state[15:0];
      cases[i].raw_b = state[31:16];
    end
    s1 = clamp_sample(adc_to_sample(cases[i].raw_a) + cases[i].level_a, c1);
    sa = clamp_sample(s1 + cases[i].offset_a, c2);
    s1 = clamp_sample(adc_to_sample(cases[i].raw_b) + cases[i].level_b, c3);
    sb = clamp_sample(s1 + cases[i].offset_b, c4);
    cases[i].exp_a   = dac_code_of(sa);
    cases[i].exp_b   = dac_code_of(sb);
    cases[i].exp_sat = {c3 | c4, c1 | c2};  // either stage clipped
  end
endtask

`endif

// File: testbench/tb_pitaya_analog.sv
//////////////////////////////////////////////////////////////////////
// testbench for the analog path top
// bus register checks, table driven mixer checks, region decode
//////////////////////////////////////////////////////////////////////

module tb_pitaya_analog;
  timeunit 1ns;
  timeprecision 100ps;

  logic                  adc_clk;
  logic                  reset_i;
  logic [15:0]           adc_dat_a_i;
  logic [15:0]           adc_dat_b_i;
  pitaya_pkg::bus_addr_t sys_addr_i;
  pitaya_pkg::bus_data_t sys_wdata_i;
  logic                  sys_wen_i;
  logic                  sys_ren_i;
  pitaya_pkg::bus_data_t sys_rdata_o;
  logic                  sys_ack_o;
  logic                  sys_err_o;
  pitaya_pkg::dac_code_t dac_dat_a_o;
  pitaya_pkg::dac_code_t dac_dat_b_o;
  logic [7:0]            led_o;

  int errors;
  int tests_run;
  int tests_failed;

  `include "tb_pitaya_cases.svh"

  localparam int TIMEOUT_CYCLES = 50 * NUM_CASES + 200;

  pitaya_analog_top #(.NUM_LEDS(8)) pitaya_analog_top_i (.*);

  initial
  begin
    adc_clk = 1'b0;
    forever #2 adc_clk = ~adc_clk;  // 4 ns period
  end

  //////////////////////////////////////////////////////////////////////
  // checks and bus access
  //////////////////////////////////////////////////////////////////////

  task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp)
    else
    begin
      $display("MISMATCH at %0d ns: %s is %h, expected %h", $time, what, got, exp);
      errors++;
    end
  endtask

  function automatic pitaya_pkg::bus_addr_t region_addr(input logic [2:0] region,
                                                        input logic [19:0] off);
    return {9'b0, region, off};  // region field in bits 22:20
  endfunction

  // ack comes one cycle after the strobe, looked at on the falling edge
  task automatic wait_ack(output pitaya_pkg::bus_data_t rdata, output logic err);
    int n;
    n = 0;
    @(negedge adc_clk);
    while (!sys_ack_o && n < 8)
    begin
      @(negedge adc_clk);
      n++;
    end
    assert (sys_ack_o)
    else
    begin
      $display("bus access to address %h was never acknowledged", sys_addr_i);
      errors++;
    end
    check("ack delay in cycles", n, 0);
    rdata = sys_rdata_o;
    err   = sys_err_o;
  endtask

  task automatic write_expect(input string what, input pitaya_pkg::bus_addr_t addr,
                              input pitaya_pkg::bus_data_t data, input logic exp_err);
    pitaya_pkg::bus_data_t ignored;
    logic                  err;
    @(posedge adc_clk);
    sys_addr_i  <= addr;
    sys_wdata_i <= data;
    sys_wen_i   <= 1'b1;
    @(posedge adc_clk);
    sys_wen_i   <= 1'b0;  // single cycle strobe
    wait_ack(ignored, err);
    check({what, " write err"}, 32'(err), 32'(exp_err));
  endtask

  task automatic read_expect(input string what, input pitaya_pkg::bus_addr_t addr,
                             input pitaya_pkg::bus_data_t exp_data, input logic exp_err);
    pitaya_pkg::bus_data_t rdata;
    logic                  err;
    @(posedge adc_clk);
    sys_addr_i <= addr;
    sys_ren_i  <= 1'b1;
    @(posedge adc_clk);
    sys_ren_i  <= 1'b0;
    wait_ack(rdata, err);
    check({what, " read err"}, 32'(err), 32'(exp_err));
    if (!exp_err)
      check({what, " read data"}, rdata, exp_data);
  endtask

  // sticky flags keep every clip since the last clear
  task automatic read_sat_held(input string what, input logic [1:0] held);
    pitaya_pkg::bus_data_t rdata;
    logic                  err;
    @(posedge adc_clk);
    sys_addr_i <= region_addr(pitaya_pkg::REGION_HK, pitaya_pkg::HK_SAT);
    sys_ren_i  <= 1'b1;
    @(posedge adc_clk);
    sys_ren_i  <= 1'b0;
    wait_ack(rdata, err);
    check({what, " read err"}, 32'(err), 32'h0);
    check({what, " held bits"}, 32'(rdata[1:0] & held), 32'(held));
  endtask

  task automatic finish_test(input string name, input int start_errors);
    tests_run++;
    if (errors == start_errors)
      $display("test %s: passed", name);
    else
    begin
      tests_failed++;
      $display("test %s: failed with %0d errors", name, errors - start_errors);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // tests
  //////////////////////////////////////////////////////////////////////

  task automatic test_reset();
    int start;
    start = errors;
    @(negedge adc_clk);
    check("dac a after reset", 32'(dac_dat_a_o), 32'h1FFF);  // code of sample 0
    check("dac b after reset", 32'(dac_dat_b_o), 32'h1FFF);
    check("leds after reset", 32'(led_o), 32'h0);
    read_expect("level a", region_addr(pitaya_pkg::REGION_HK, pitaya_pkg::HK_LEVEL_A), 0, 0);
    read_expect("level b", region_addr(pitaya_pkg::REGION_HK, pitaya_pkg::HK_LEVEL_B), 0, 0);
    read_expect("offset a", region_addr(pitaya_pkg::REGION_HK, pitaya_pkg::HK_OFFSET_A), 0, 0);
    read_expect("offset b", region_addr(pitaya_pkg::REGION_HK, pitaya_pkg::HK_OFFSET_B), 0, 0);
    read_expect("sat flags", region_addr(pitaya_pkg::REGION_HK, pitaya_pkg::HK_SAT), 0, 0);
    finish_test("reset state", start);
  endtask

  task automatic test_registers();
    int start;
    start = errors;
    // upper bits beyond each field are dropped
    write_expect("led", region_addr(pitaya_pkg::REGION_HK, pitaya_pkg::HK_LED), 32'hFFFF_FF5A, 0);
    read_expect("led", region_addr(pitaya_pkg::REGION_HK, pitaya_pkg::HK_LED), 32'h5A, 0);
    check("led pins", 32'(led_o), 32'h5A);
    write_expect("level a", region_addr(pitaya_pkg::REGION_HK, pitaya_pkg::HK_LEVEL_A),
                 32'hFFFF_E123, 0);
    read_expect("level a", region_addr(pitaya_pkg::REGION_HK, pitaya_pkg::HK_LEVEL_A), 32'h2123, 0);
    write_expect("level b", region_addr(pitaya_pkg::REGION_HK, pitaya_pkg::HK_LEVEL_B), 32'h1ABC, 0);
    read_expect("level b", region_addr(pitaya_pkg::REGION_HK, pitaya_pkg::HK_LEVEL_B), 32'h1ABC, 0);
    write_expect("offset a", region_addr(pitaya_pkg::REGION_HK, pitaya_pkg::HK_OFFSET_A),
                 32'h3FFF, 0);
    read_expect("offset a", region_addr(pitaya_pkg::REGION_HK, pitaya_pkg::HK_OFFSET_A),
                32'h3FFF, 0);
    write_expect("offset b", region_addr(pitaya_pkg::REGION_HK, pitaya_pkg::HK_OFFSET_B),
                 32'h8000_0001, 0);
    read_expect("offset b", region_addr(pitaya_pkg::REGION_HK, pitaya_pkg::HK_OFFSET_B),
                32'h0001, 0);
    // id is read only, holes answer with err
    read_expect("id", region_addr(pitaya_pkg::REGION_HK, pitaya_pkg::HK_ID),
                pitaya_pkg::HK_ID_VALUE, 0);
    write_expect("id", region_addr(pitaya_pkg::REGION_HK, pitaya_pkg::HK_ID), 32'h1234, 1);
    read_expect("id after write", region_addr(pitaya_pkg::REGION_HK, pitaya_pkg::HK_ID),
                pitaya_pkg::HK_ID_VALUE, 0);
    write_expect("unknown offset", region_addr(pitaya_pkg::REGION_HK, 20'h40), 32'h1, 1);
    read_expect("unknown offset", region_addr(pitaya_pkg::REGION_HK, 20'h08), 32'h0, 1);
    finish_test("registers", start);
  endtask

  task automatic run_case(input int i);
    mix_case_t  c;
    int         start;
    logic [1:0] held;
    c     = cases[i];
    start = errors;
    held  = c.exp_sat;
    if (i > 0)
      held = held | cases[i-1].exp_sat;  // earlier clips stay until cleared
    write_expect("level a", region_addr(pitaya_pkg::REGION_HK, pitaya_pkg::HK_LEVEL_A),
                 c.level_a, 0);
    write_expect("level b", region_addr(pitaya_pkg::REGION_HK, pitaya_pkg::HK_LEVEL_B),
                 c.level_b, 0);
    write_expect("offset a", region_addr(pitaya_pkg::REGION_HK, pitaya_pkg::HK_OFFSET_A),
                 c.offset_a, 0);
    write_expect("offset b", region_addr(pitaya_pkg::REGION_HK, pitaya_pkg::HK_OFFSET_B),
                 c.offset_b, 0);
    @(posedge adc_clk);
    adc_dat_a_i <= c.raw_a;
    adc_dat_b_i <= c.raw_b;
    repeat (4) @(posedge adc_clk);  // capture edge, then three pipeline edges
    @(negedge adc_clk);
    check($sformatf("case %0d dac a", i), 32'(dac_dat_a_o), 32'(c.exp_a));
    check($sformatf("case %0d dac b", i), 32'(dac_dat_b_o), 32'(c.exp_b));
    read_sat_held($sformatf("case %0d sticky sat", i), held);
    // pipeline now steady, clear leaves only this case's clips
    write_expect("sat clear", region_addr(pitaya_pkg::REGION_HK, pitaya_pkg::HK_SAT), 32'h0, 0);
    read_expect($sformatf("case %0d sat flags", i),
                region_addr(pitaya_pkg::REGION_HK, pitaya_pkg::HK_SAT), 32'(c.exp_sat), 0);
    read_expect($sformatf("case %0d sample window", i),
                region_addr(pitaya_pkg::REGION_SAMPLES, 20'h0), window_word(c.raw_a, c.raw_b), 0);
    finish_test($sformatf("mix case %0d", i), start);
  endtask

  task automatic test_regions();
    int start;
    start = errors;
    write_expect("led", region_addr(pitaya_pkg::REGION_HK, pitaya_pkg::HK_LED), 32'h3C, 0);
    for (int r = 2; r < 8; r++)
    begin
      read_expect($sformatf("region %0d", r), region_addr(3'(r), pitaya_pkg::HK_LED), 32'h0, 0);
      write_expect($sformatf("region %0d", r), region_addr(3'(r), pitaya_pkg::HK_LED),
                   32'hFF, 0);
    end
    read_expect("led kept", region_addr(pitaya_pkg::REGION_HK, pitaya_pkg::HK_LED), 32'h3C, 0);
    check("led pins kept", 32'(led_o), 32'h3C);
    write_expect("sample window", region_addr(pitaya_pkg::REGION_SAMPLES, 20'h0), 32'h1, 1);
    finish_test("regions", start);
  endtask

  //////////////////////////////////////////////////////////////////////
  // main sequence and watchdog
  //////////////////////////////////////////////////////////////////////

  initial
  begin
    errors       = 0;
    tests_run    = 0;
    tests_failed = 0;
    reset_i      = 1'b1;
    adc_dat_a_i  = 16'h7FFC;  // code of sample 0
    adc_dat_b_i  = 16'h7FFC;
    sys_addr_i   = '0;
    sys_wdata_i  = '0;
    sys_wen_i    = 1'b0;
    sys_ren_i    = 1'b0;
    prepare_cases();
    repeat (2) @(posedge adc_clk);
    reset_i <= 1'b0;
    test_reset();
    test_registers();
    for (int i = 0; i < NUM_CASES; i++)
      run_case(i);
    test_regions();
    $display("%0d tests run, %0d failed, %0d failed checks", tests_run, tests_failed, errors);
    if (errors == 0)
      $display("Finished with no errors");
    else
      $display("Finished with errors");
    $finish;
  end

  initial
  begin
    int cycle_count;
    cycle_count = 0;
    while (cycle_count < TIMEOUT_CYCLES)
    begin
      @(posedge adc_clk);
      cycle_count++;
    end
    $display("timeout after %0d cycles, the tests did not complete", cycle_count);
    $display("Finished with errors");
    $finish;
  end

endmodule

// File: sim.f
+incdir+include
hdl/pitaya_pkg.sv
hdl/sys_bus_decoder.sv
hdl/housekeeping_regs.sv
hdl/adc_front_end.sv
hdl/dac_mixer.sv
hdl/pitaya_analog_top.sv
testbench/tb_pitaya_analog.sv

// File: Makefile
TOP = tb_pitaya_analog

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f sim.f --top-module $(TOP) -Mdir obj_dir -o $(TOP)

run: compile
	out=$$(./obj_dir/$(TOP)); echo "$$out"; echo "$$out" | grep -qx "Finished with no errors"

clean:
	rm -rf obj_dir
